// ==== hdl/i2c_bus_pkg.sv ====
`default_nettype none

package i2c_bus_pkg;

    localparam int BYTE_BITS = 8;
    localparam int ADDR_BITS = 7;

    // Direction bit in the address byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // Address byte, built field by field and shifted out whole
    typedef union packed {
        logic [BYTE_BITS-1:0] raw;
        struct packed {
            logic [ADDR_BITS-1:0] dev;
            logic                 rw;
        } f;
    } addr_byte_u;

endpackage

`default_nettype wire

// ==== hdl/i2c_ctrl_pkg.sv ====
`default_nettype none

package i2c_ctrl_pkg;

    localparam int DIV_BITS     = 16;
    localparam int PHASES       = 4;
    localparam int PHASE_BITS   = 2;
    // SCL has been high for a full phase by the end of this one
    localparam int SAMPLE_PHASE = 2;

    // Bit operations
    localparam int OP_BITS = 3;
    localparam logic [OP_BITS-1:0] OP_START   = 3'd0;
    localparam logic [OP_BITS-1:0] OP_RESTART = 3'd1;
    localparam logic [OP_BITS-1:0] OP_STOP    = 3'd2;
    localparam logic [OP_BITS-1:0] OP_WRITE   = 3'd3;
    localparam logic [OP_BITS-1:0] OP_READ    = 3'd4;

    // Sequencer states
    localparam int ST_BITS = 4;
    localparam logic [ST_BITS-1:0] ST_IDLE      = 4'd0;
    localparam logic [ST_BITS-1:0] ST_START     = 4'd1;
    localparam logic [ST_BITS-1:0] ST_ADDR_W    = 4'd2;
    localparam logic [ST_BITS-1:0] ST_REG       = 4'd3;
    localparam logic [ST_BITS-1:0] ST_DATA_W    = 4'd4;
    localparam logic [ST_BITS-1:0] ST_RESTART   = 4'd5;
    localparam logic [ST_BITS-1:0] ST_ADDR_R    = 4'd6;
    localparam logic [ST_BITS-1:0] ST_DATA_R    = 4'd7;
    localparam logic [ST_BITS-1:0] ST_NACK      = 4'd8;
    localparam logic [ST_BITS-1:0] ST_STOP      = 4'd9;
    localparam logic [ST_BITS-1:0] ST_ACK_CHECK = 4'd10;

endpackage

`default_nettype wire

// ==== hdl/i2c_tick_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_tick_gen (
    input  wire logic                              i_clk,
    input  wire logic                              i_rst,
    input  wire logic [i2c_ctrl_pkg::DIV_BITS-1:0] i_divider,
    output logic                                   o_tick
);

    logic [i2c_ctrl_pkg::DIV_BITS-1:0] count;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            count <= '0;
        end else if (count >= i_divider) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    assign o_tick = (count == i_divider);

    // Divider must hold still while the count runs
    a_count_in_range: assert property (
        @(posedge i_clk) disable iff (i_rst) count <= i_divider
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_bit_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_engine (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst,
    input  wire logic                             i_tick,
    input  wire logic                             i_op_valid,
    input  wire logic [i2c_ctrl_pkg::OP_BITS-1:0] i_op_code,
    input  wire logic                             i_op_bit,
    output logic                                  o_op_ready,
    output logic                                  o_op_done,
    output logic                                  o_rx_bit,
    input  wire logic                             i_sda,
    output logic                                  o_scl_low,
    output logic                                  o_sda_low
);

    logic                                busy;
    logic [i2c_ctrl_pkg::PHASE_BITS-1:0] phase;
    logic [i2c_ctrl_pkg::OP_BITS-1:0]    op_q;
    logic                                bit_q;

    // Pull-low pair {scl, sda} for one phase of one operation
    function automatic logic [1:0] line_levels(
        input logic [i2c_ctrl_pkg::OP_BITS-1:0]    op,
        input logic [i2c_ctrl_pkg::PHASE_BITS-1:0] ph,
        input logic                                b
    );
        logic scl_l;
        logic sda_l;
        scl_l = (ph == 2'd0) || (ph == 2'd3);
        sda_l = 1'b0;
        case (op)
            i2c_ctrl_pkg::OP_START: begin
                scl_l = (ph == 2'd3);
                sda_l = (ph != 2'd0);
            end
            // SCL up with SDA high, then a START inside the same slot
            i2c_ctrl_pkg::OP_RESTART: begin
                sda_l = (ph >= 2'd2);
            end
            i2c_ctrl_pkg::OP_STOP: begin
                scl_l = (ph == 2'd0);
                sda_l = (ph <= 2'd1);
            end
            i2c_ctrl_pkg::OP_WRITE: begin
                sda_l = !b;
            end
            default: begin
                sda_l = 1'b0;
            end
        endcase
        return {scl_l, sda_l};
    endfunction

    assign o_op_ready = !busy;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy      <= 1'b0;
            phase     <= '0;
            o_op_done <= 1'b0;
            o_scl_low <= 1'b0;
            o_sda_low <= 1'b0;
        end else begin
            o_op_done <= 1'b0;
            if (!busy) begin
                if (i_op_valid) begin
                    busy                   <= 1'b1;
                    phase                  <= '0;
                    {o_scl_low, o_sda_low} <= line_levels(i_op_code, '0, i_op_bit);
                end
            end else if (i_tick) begin
                if (phase == 2'(i2c_ctrl_pkg::PHASES - 1)) begin
                    // Lines keep their last phase until the next operation
                    busy      <= 1'b0;
                    o_op_done <= 1'b1;
                end else begin
                    phase                  <= phase + 1'b1;
                    {o_scl_low, o_sda_low} <= line_levels(op_q, phase + 1'b1, bit_q);
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy && i_op_valid) begin
            op_q  <= i_op_code;
            bit_q <= i_op_bit;
        end
        if (busy && i_tick && op_q == i2c_ctrl_pkg::OP_READ &&
            phase == 2'(i2c_ctrl_pkg::SAMPLE_PHASE)) begin
            o_rx_bit <= i_sda;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    a_no_overlap: assert property (
        @(posedge i_clk) disable iff (i_rst) busy |-> !i_op_valid
    );

    // Data bits, from either side, settle only while SCL is low
    a_sda_stable: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (busy && $past(busy) && !o_scl_low && !$past(o_scl_low) &&
         (op_q == i2c_ctrl_pkg::OP_WRITE || op_q == i2c_ctrl_pkg::OP_READ))
        |-> $stable(i_sda)
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_sequencer (
    input  wire logic                               i_clk,
    input  wire logic                               i_rst,
    input  wire logic                               i_cmd_valid,
    input  wire logic                               i_cmd_rw,
    input  wire logic [i2c_bus_pkg::ADDR_BITS-1:0]  i_cmd_dev,
    input  wire logic [i2c_bus_pkg::BYTE_BITS-1:0]  i_cmd_reg,
    input  wire logic [i2c_bus_pkg::BYTE_BITS-1:0]  i_cmd_wdata,
    output logic                                    o_cmd_ready,
    output logic                                    o_op_valid,
    output logic [i2c_ctrl_pkg::OP_BITS-1:0]        o_op_code,
    output logic                                    o_op_bit,
    input  wire logic                               i_op_ready,
    input  wire logic                               i_op_done,
    input  wire logic                               i_rx_bit,
    output logic                                    o_rsp_valid,
    output logic                                    o_rsp_nack,
    output logic [i2c_bus_pkg::BYTE_BITS-1:0]       o_rsp_rdata
);

    logic [i2c_ctrl_pkg::ST_BITS-1:0]            state;
    logic [i2c_ctrl_pkg::ST_BITS-1:0]            ret_state;
    logic [$clog2(i2c_bus_pkg::BYTE_BITS)-1:0]   bit_cnt;
    logic                                        byte_last;
    logic                                        waiting;
    logic                                        cmd_take;
    logic [i2c_bus_pkg::BYTE_BITS-1:0]           shreg;
    logic [i2c_bus_pkg::BYTE_BITS-1:0]           reg_q;
    logic [i2c_bus_pkg::BYTE_BITS-1:0]           wdata_q;
    logic [i2c_bus_pkg::ADDR_BITS-1:0]           dev_q;
    logic                                        rw_q;
    i2c_bus_pkg::addr_byte_u                     addr_w;
    i2c_bus_pkg::addr_byte_u                     addr_r;

    assign o_cmd_ready = (state == i2c_ctrl_pkg::ST_IDLE);
    assign cmd_take    = o_cmd_ready && i_cmd_valid;
    assign byte_last   = (bit_cnt == 3'(i2c_bus_pkg::BYTE_BITS - 1));

    always_comb begin
        addr_w.f.dev = i_cmd_dev;
        addr_w.f.rw  = i2c_bus_pkg::RW_WRITE;
        addr_r.f.dev = dev_q;
        addr_r.f.rw  = i2c_bus_pkg::RW_READ;
    end

    // Operation for the current state
    always_comb begin
        o_op_bit = 1'b1;
        case (state)
            i2c_ctrl_pkg::ST_START:   o_op_code = i2c_ctrl_pkg::OP_START;
            i2c_ctrl_pkg::ST_RESTART: o_op_code = i2c_ctrl_pkg::OP_RESTART;
            i2c_ctrl_pkg::ST_NACK:    o_op_code = i2c_ctrl_pkg::OP_WRITE;
            i2c_ctrl_pkg::ST_STOP:    o_op_code = i2c_ctrl_pkg::OP_STOP;
            i2c_ctrl_pkg::ST_ADDR_W, i2c_ctrl_pkg::ST_REG,
            i2c_ctrl_pkg::ST_DATA_W, i2c_ctrl_pkg::ST_ADDR_R: begin
                o_op_code = i2c_ctrl_pkg::OP_WRITE;
                o_op_bit  = shreg[i2c_bus_pkg::BYTE_BITS-1];
            end
            default:                  o_op_code = i2c_ctrl_pkg::OP_READ;
        endcase
    end

    //////////////////////////////////////////////////
    // Transaction FSM

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= i2c_ctrl_pkg::ST_IDLE;
            ret_state   <= i2c_ctrl_pkg::ST_IDLE;
            bit_cnt     <= '0;
            waiting     <= 1'b0;
            o_op_valid  <= 1'b0;
            o_rsp_valid <= 1'b0;
            o_rsp_nack  <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            if (o_op_valid && i_op_ready) begin
                o_op_valid <= 1'b0;
                waiting    <= 1'b1;
            end else if (!o_cmd_ready && !o_op_valid && !waiting) begin
                o_op_valid <= 1'b1;
            end

            if (cmd_take) begin
                state      <= i2c_ctrl_pkg::ST_START;
                bit_cnt    <= '0;
                o_rsp_nack <= 1'b0;
            end

            if (i_op_done) begin
                waiting <= 1'b0;
                case (state)
                    i2c_ctrl_pkg::ST_START:   state <= i2c_ctrl_pkg::ST_ADDR_W;
                    i2c_ctrl_pkg::ST_RESTART: state <= i2c_ctrl_pkg::ST_ADDR_R;
                    i2c_ctrl_pkg::ST_NACK:    state <= i2c_ctrl_pkg::ST_STOP;
                    i2c_ctrl_pkg::ST_ADDR_W, i2c_ctrl_pkg::ST_REG,
                    i2c_ctrl_pkg::ST_DATA_W, i2c_ctrl_pkg::ST_ADDR_R: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (byte_last) begin
                            state <= i2c_ctrl_pkg::ST_ACK_CHECK;
                            case (state)
                                i2c_ctrl_pkg::ST_ADDR_W: ret_state <= i2c_ctrl_pkg::ST_REG;
                                i2c_ctrl_pkg::ST_DATA_W: ret_state <= i2c_ctrl_pkg::ST_STOP;
                                i2c_ctrl_pkg::ST_ADDR_R: ret_state <= i2c_ctrl_pkg::ST_DATA_R;
                                default: begin
                                    ret_state <= (rw_q == i2c_bus_pkg::RW_READ) ?
                                                 i2c_ctrl_pkg::ST_RESTART :
                                                 i2c_ctrl_pkg::ST_DATA_W;
                                end
                            endcase
                        end
                    end
                    i2c_ctrl_pkg::ST_ACK_CHECK: begin
                        // Released SDA on the ack slot means nobody answered
                        if (i_rx_bit) begin
                            o_rsp_nack <= 1'b1;
                            state      <= i2c_ctrl_pkg::ST_STOP;
                        end else begin
                            state <= ret_state;
                        end
                    end
                    i2c_ctrl_pkg::ST_DATA_R: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (byte_last) begin
                            state <= i2c_ctrl_pkg::ST_NACK;
                        end
                    end
                    i2c_ctrl_pkg::ST_STOP: begin
                        state       <= i2c_ctrl_pkg::ST_IDLE;
                        o_rsp_valid <= 1'b1;
                    end
                    default: state <= i2c_ctrl_pkg::ST_IDLE;
                endcase
            end
        end
    end

    // Command fields and byte shifters
    always_ff @(posedge i_clk) begin
        if (cmd_take) begin
            rw_q    <= i_cmd_rw;
            dev_q   <= i_cmd_dev;
            reg_q   <= i_cmd_reg;
            wdata_q <= i_cmd_wdata;
            shreg   <= addr_w.raw;
        end else if (i_op_done) begin
            case (state)
                i2c_ctrl_pkg::ST_ADDR_W, i2c_ctrl_pkg::ST_REG,
                i2c_ctrl_pkg::ST_DATA_W, i2c_ctrl_pkg::ST_ADDR_R: begin
                    if (!byte_last) begin
                        shreg <= shreg << 1;
                    end else if (state == i2c_ctrl_pkg::ST_ADDR_W) begin
                        shreg <= reg_q;
                    end else if (state == i2c_ctrl_pkg::ST_REG) begin
                        shreg <= (rw_q == i2c_bus_pkg::RW_READ) ? addr_r.raw : wdata_q;
                    end
                end
                i2c_ctrl_pkg::ST_DATA_R: begin
                    o_rsp_rdata <= {o_rsp_rdata[i2c_bus_pkg::BYTE_BITS-2:0], i_rx_bit};
                end
                default: begin
                    shreg <= shreg;
                end
            endcase
        end
    end

    a_rsp_pulse: assert property (
        @(posedge i_clk) disable iff (i_rst) o_rsp_valid |=> !o_rsp_valid
    );

endmodule

`default_nettype wire

// ==== hdl/i2c_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_master (
    input  wire logic                              i_clk,
    input  wire logic                              i_rst,
    input  wire logic [i2c_ctrl_pkg::DIV_BITS-1:0] i_divider,
    input  wire logic                              i_cmd_valid,
    input  wire logic                              i_cmd_rw,
    input  wire logic [i2c_bus_pkg::ADDR_BITS-1:0] i_cmd_dev,
    input  wire logic [i2c_bus_pkg::BYTE_BITS-1:0] i_cmd_reg,
    input  wire logic [i2c_bus_pkg::BYTE_BITS-1:0] i_cmd_wdata,
    output logic                                   o_cmd_ready,
    output logic                                   o_rsp_valid,
    output logic                                   o_rsp_nack,
    output logic [i2c_bus_pkg::BYTE_BITS-1:0]      o_rsp_rdata,
    input  wire logic                              i_scl,
    input  wire logic                              i_sda,
    output logic                                   o_scl_low,
    output logic                                   o_sda_low
);

    logic                             tick;
    logic                             op_valid;
    logic [i2c_ctrl_pkg::OP_BITS-1:0] op_code;
    logic                             op_bit;
    logic                             op_ready;
    logic                             op_done;
    logic                             rx_bit;

    i2c_tick_gen u_tick_gen (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_divider (i_divider),
        .o_tick    (tick)
    );

    i2c_bit_engine u_bit_engine (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_tick     (tick),
        .i_op_valid (op_valid),
        .i_op_code  (op_code),
        .i_op_bit   (op_bit),
        .o_op_ready (op_ready),
        .o_op_done  (op_done),
        .o_rx_bit   (rx_bit),
        .i_sda      (i_sda),
        .o_scl_low  (o_scl_low),
        .o_sda_low  (o_sda_low)
    );

    i2c_sequencer u_sequencer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_rw    (i_cmd_rw),
        .i_cmd_dev   (i_cmd_dev),
        .i_cmd_reg   (i_cmd_reg),
        .i_cmd_wdata (i_cmd_wdata),
        .o_cmd_ready (o_cmd_ready),
        .o_op_valid  (op_valid),
        .o_op_code   (op_code),
        .o_op_bit    (op_bit),
        .i_op_ready  (op_ready),
        .i_op_done   (op_done),
        .i_rx_bit    (rx_bit),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_nack  (o_rsp_nack),
        .o_rsp_rdata (o_rsp_rdata)
    );

    // No clock stretching, SCL must follow our own drive
    a_scl_free: assert property (
        @(posedge i_clk) disable iff (i_rst) !o_scl_low |-> i_scl
    );

endmodule

`default_nettype wire

// ==== test/i2c_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_clk_gen (
    output logic o_clk
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

// ==== test/i2c_slave_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model #(
    parameter logic [i2c_bus_pkg::ADDR_BITS-1:0] DEV_ADDR = '0
) (
    input  wire logic i_scl,
    input  wire logic i_sda,
    output logic      o_sda_low
);

    localparam int S_IDLE  = 0;
    localparam int S_ADDR  = 1;
    localparam int S_REG   = 2;
    localparam int S_WDATA = 3;
    localparam int S_ACK   = 4;
    localparam int S_RDATA = 5;
    localparam int S_MACK  = 6;

    logic [i2c_bus_pkg::BYTE_BITS-1:0] mem [256];
    logic [i2c_bus_pkg::BYTE_BITS-1:0] shift;
    logic [i2c_bus_pkg::BYTE_BITS-1:0] reg_ptr;
    logic [3:0]                        bit_cnt;
    int                                state;
    int                                next_state;
    logic                              scl_q;
    logic                              sda_q;

    // Pull SDA for the ack slot, continue in the given state
    task automatic send_ack(input int after);
        o_sda_low  = 1'b1;
        state      = S_ACK;
        next_state = after;
    endtask

    initial begin
        logic [7:0] a;
        a = 8'd0;
        repeat (256) begin
            mem[a] = {a[3:0], a[7:4]} ^ 8'h3C;
            a      = a + 8'd1;
        end
        o_sda_low  = 1'b0;
        state      = S_IDLE;
        next_state = S_IDLE;
        bit_cnt    = 4'd0;
        shift      = 8'd0;
        reg_ptr    = 8'd0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        forever begin
            @(i_scl or i_sda);
            if (scl_q === 1'b1 && i_scl === 1'b1 && sda_q === 1'b1 && i_sda === 1'b0) begin
                // START or repeated START
                state     = S_ADDR;
                bit_cnt   = 4'd0;
                o_sda_low = 1'b0;
            end else if (scl_q === 1'b1 && i_scl === 1'b1 && sda_q === 1'b0 && i_sda === 1'b1) begin
                state     = S_IDLE;
                o_sda_low = 1'b0;
            end else if (scl_q === 1'b0 && i_scl === 1'b1) begin
                case (state)
                    S_ADDR, S_REG, S_WDATA: begin
                        shift   = {shift[6:0], i_sda};
                        bit_cnt = bit_cnt + 4'd1;
                    end
                    S_RDATA: begin
                        bit_cnt = bit_cnt + 4'd1;
                    end
                    // One byte per read
                    S_MACK: begin
                        state = S_IDLE;
                    end
                    default: begin
                    end
                endcase
            end else if (scl_q === 1'b1 && i_scl === 1'b0) begin
                case (state)
                    S_ADDR: begin
                        if (bit_cnt == 4'd8 && shift[7:1] == DEV_ADDR) begin
                            send_ack(shift[0] ? S_RDATA : S_REG);
                        end else if (bit_cnt == 4'd8) begin
                            state = S_IDLE;
                        end
                    end
                    S_REG: begin
                        if (bit_cnt == 4'd8) begin
                            reg_ptr = shift;
                            send_ack(S_WDATA);
                        end
                    end
                    S_WDATA: begin
                        if (bit_cnt == 4'd8) begin
                            mem[reg_ptr] = shift;
                            reg_ptr      = reg_ptr + 8'd1;
                            send_ack(S_WDATA);
                        end
                    end
                    S_ACK: begin
                        o_sda_low = 1'b0;
                        bit_cnt   = 4'd0;
                        state     = next_state;
                        if (next_state == S_RDATA) begin
                            shift     = mem[reg_ptr];
                            o_sda_low = !shift[7];
                        end
                    end
                    S_RDATA: begin
                        if (bit_cnt == 4'd8) begin
                            o_sda_low = 1'b0;
                            state     = S_MACK;
                        end else begin
                            shift     = shift << 1;
                            o_sda_low = !shift[7];
                        end
                    end
                    default: begin
                    end
                endcase
            end
            scl_q = i_scl;
            sda_q = i_sda;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_i2c_master.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_master;

    localparam logic [i2c_bus_pkg::ADDR_BITS-1:0] SLAVE_ADDR = 7'h42;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_PAIRS   = 40;

    logic                              clk;
    logic                              rst;
    logic [i2c_ctrl_pkg::DIV_BITS-1:0] divider;
    logic                              cmd_valid;
    logic                              cmd_rw;
    logic [i2c_bus_pkg::ADDR_BITS-1:0] cmd_dev;
    logic [i2c_bus_pkg::BYTE_BITS-1:0] cmd_reg;
    logic [i2c_bus_pkg::BYTE_BITS-1:0] cmd_wdata;
    logic                              cmd_ready;
    logic                              rsp_valid;
    logic                              rsp_nack;
    logic [i2c_bus_pkg::BYTE_BITS-1:0] rsp_rdata;
    logic                              scl_low;
    logic                              sda_low;
    logic                              slave_sda_low;
    logic                              scl;
    logic                              sda;
    logic [i2c_bus_pkg::BYTE_BITS-1:0] shadow [256];
    integer                            seed;

    // Wired-AND bus without clock stretching
    assign scl = !scl_low;
    assign sda = !(sda_low || slave_sda_low);

    i2c_clk_gen u_clk_gen (
        .o_clk (clk)
    );

    i2c_master i_i2c_master (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_divider   (divider),
        .i_cmd_valid (cmd_valid),
        .i_cmd_rw    (cmd_rw),
        .i_cmd_dev   (cmd_dev),
        .i_cmd_reg   (cmd_reg),
        .i_cmd_wdata (cmd_wdata),
        .o_cmd_ready (cmd_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp_nack  (rsp_nack),
        .o_rsp_rdata (rsp_rdata),
        .i_scl       (scl),
        .i_sda       (sda),
        .o_scl_low   (scl_low),
        .o_sda_low   (sda_low)
    );

    i2c_slave_model #(
        .DEV_ADDR (SLAVE_ADDR)
    ) u_slave (
        .i_scl     (scl),
        .i_sda     (sda),
        .o_sda_low (slave_sda_low)
    );

    //////////////////////////////////////////////////
    // Checks

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns: %s is %b, expected %b",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_nack(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns: o_rsp_nack is %b, expected %b",
                                $time, got, exp));
        end
    endtask

    task automatic check_rdata(input logic [i2c_bus_pkg::BYTE_BITS-1:0] got,
                               input logic [i2c_bus_pkg::BYTE_BITS-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0d ns: o_rsp_rdata is %h, expected %h",
                                $time, got, exp));
        end
    endtask

    // Power-up content of the slave registers
    function automatic logic [7:0] fill_value(input logic [7:0] a);
        return {a[3:0], a[7:4]} ^ 8'h3C;
    endfunction

    task automatic run_transaction(
        input logic                              rw,
        input logic [i2c_bus_pkg::ADDR_BITS-1:0] dev,
        input logic [i2c_bus_pkg::BYTE_BITS-1:0] reg_addr,
        input logic [i2c_bus_pkg::BYTE_BITS-1:0] wdata,
        input logic                              exp_nack,
        input logic [i2c_bus_pkg::BYTE_BITS-1:0] exp_rdata
    );
        int waited;
        waited = 0;
        @(negedge clk);
        while (cmd_ready !== 1'b1) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for o_cmd_ready to rise");
            end
            @(negedge clk);
        end
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_rw    <= rw;
        cmd_dev   <= dev;
        cmd_reg   <= reg_addr;
        cmd_wdata <= wdata;
        @(posedge clk);
        cmd_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (rsp_valid !== 1'b1) begin
            check_flag(cmd_ready, 1'b0, "o_cmd_ready during transaction");
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                abort_run("Timed out waiting for o_rsp_valid");
            end
            @(negedge clk);
        end
        check_nack(rsp_nack, exp_nack);
        if (rw == i2c_bus_pkg::RW_READ && !exp_nack) begin
            check_rdata(rsp_rdata, exp_rdata);
        end
        check_flag(scl, 1'b1, "SCL after response");
        check_flag(sda, 1'b1, "SDA after response");
        @(negedge clk);
        check_flag(rsp_valid, 1'b0, "o_rsp_valid one cycle after response");
        check_flag(cmd_ready, 1'b1, "o_cmd_ready after response");
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    initial begin
        int                                fd;
        int                                n;
        string                             line;
        logic                              f_rw;
        logic [i2c_bus_pkg::ADDR_BITS-1:0] f_dev;
        logic [i2c_bus_pkg::BYTE_BITS-1:0] f_reg;
        logic [i2c_bus_pkg::BYTE_BITS-1:0] f_wdata;
        logic [i2c_ctrl_pkg::DIV_BITS-1:0] f_div;
        logic                              f_nack;
        logic [i2c_bus_pkg::BYTE_BITS-1:0] f_rdata;
        logic [7:0]                        a;
        logic [7:0]                        r;
        logic [7:0]                        d;
        logic [7:0]                        q;

        seed      = 13084;
        rst       <= 1'b1;
        divider   <= '0;
        cmd_valid <= 1'b0;
        cmd_rw    <= 1'b0;
        cmd_dev   <= '0;
        cmd_reg   <= '0;
        cmd_wdata <= '0;
        a = 8'd0;
        repeat (256) begin
            shadow[a] = fill_value(a);
            a         = a + 8'd1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag(cmd_ready, 1'b1, "o_cmd_ready after reset");
        check_flag(rsp_valid, 1'b0, "o_rsp_valid after reset");
        check_flag(scl, 1'b1, "SCL after reset");
        check_flag(sda, 1'b1, "SDA after reset");

        fd = $fopen("test/i2c_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open test/i2c_testdata.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %d %h %h",
                            f_rw, f_dev, f_reg, f_wdata, f_div, f_nack, f_rdata);
                if (n == 7) begin
                    @(posedge clk);
                    divider <= f_div;
                    run_transaction(f_rw, f_dev, f_reg, f_wdata, f_nack, f_rdata);
                    if (f_rw == i2c_bus_pkg::RW_WRITE && !f_nack) begin
                        shadow[f_reg] = f_wdata;
                    end
                end else if (n > 0) begin
                    abort_run("Malformed line in test/i2c_testdata.txt");
                end
            end
        end
        $fclose(fd);

        // Random pairs at the last divider of the file
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            r = 8'($random(seed));
            d = 8'($random(seed));
            run_transaction(i2c_bus_pkg::RW_WRITE, SLAVE_ADDR, r, d, 1'b0, 8'h00);
            shadow[r] = d;
            q = ($random(seed) & 1) ? r : 8'($random(seed));
            run_transaction(i2c_bus_pkg::RW_READ, SLAVE_ADDR, q, 8'h00, 1'b0, shadow[q]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/i2c_testdata.txt ====
# rw dev reg wdata divider nack rdata, hex except the decimal divider
# rw 0 writes, 1 reads; rdata counts for reads without nack; divider never decreases
0 42 20 5a 0 0 00
1 42 20 00 0 0 5a
1 42 10 00 0 0 3d
0 13 20 99 0 1 00
1 42 20 00 0 0 5a
1 13 20 00 3 1 00
0 42 ff c3 3 0 00
1 42 ff 00 3 0 c3
0 42 00 01 20 0 00
1 42 00 00 20 0 01
1 42 a7 00 20 0 46

// ==== all.f ====
hdl/i2c_bus_pkg.sv
hdl/i2c_ctrl_pkg.sv
hdl/i2c_tick_gen.sv
hdl/i2c_bit_engine.sv
hdl/i2c_sequencer.sv
hdl/i2c_master.sv
test/i2c_clk_gen.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FLAGS     ?= --assert
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f all.f

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF '$(PASS_MSG)'; then \
		echo "Simulation result: pass"; \
	else \
		echo "Simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
